//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_alpha_controller
FILE_LIST ?= build.f
OBJ_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --assert -j 0
PASS_TEXT ?= SIMULATION PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- alpha_config_pkg.sv
package alpha_config_pkg;

	// configuration word as the chip expects it, lsb shifted first
	typedef logic [15:0] config_word_t;

	// bit select into the word, wraps so dummy slots repeat bits 0..3
	typedef logic [3:0] bit_index_t;

	// 16 data slots plus 4 dummy slots
	localparam int slot_count = 20;

	typedef logic [4:0] slot_index_t; // counts up to slot_count

endpackage

//--- alpha_control_if.sv
interface alpha_control_if;

	// raw sequencer levels, not yet registered at the pins
	logic dreset; // chip digital reset
	logic sync;
	logic tok_a_f2t; // token toward the top chip
	logic trig_top;
	logic sin; // serial config data
	logic sclk; // serial config clock

	modport startup (
		output dreset,
		output sync,
		output tok_a_f2t,
		output trig_top
	);

	// config shifter side
	modport cfg (
		output sin,
		output sclk
	);

	modport pins (
		input dreset, sync, tok_a_f2t, trig_top,
		input sin, sclk
	);

endinterface

//--- alpha_controller_asserts.sv
module alpha_controller_asserts (
	input logic clock,
	input logic reset,
	input logic dreset,
	input logic sync,
	input logic tok_a_f2t,
	input logic trig_top,
	input logic sin,
	input logic sclk,
	input logic pclk_t,
	input logic pclk_m,
	input logic pclk_b
);
	timeunit 1ns;
	timeprecision 1ps;

	int failures = 0; // read by the testbench at the end

	startup_lines_exclusive: assert property (@(posedge clock) disable iff (reset)
		$onehot0({dreset, sync, tok_a_f2t, trig_top}))
		else begin
			failures++;
			$error("more than one startup line high at once");
		end

	// chip clocks follow the chip reset
	pclk_follow_dreset: assert property (@(posedge clock) disable iff (reset)
		(pclk_t == dreset) && (pclk_m == dreset) && (pclk_b == dreset))
		else begin
			failures++;
			$error("pclk lines differ from dreset");
		end

	outputs_low_after_reset: assert property (@(posedge clock)
		reset |=> !(|{dreset, sync, tok_a_f2t, trig_top, sin, sclk, pclk_t, pclk_m, pclk_b}))
		else begin
			failures++;
			$error("pin output high right after reset");
		end

endmodule

bind alpha_pin_driver alpha_controller_asserts alpha_controller_asserts_inst (
	.clock(clock),
	.reset(reset),
	.dreset(dreset),
	.sync(sync),
	.tok_a_f2t(tok_a_f2t),
	.trig_top(trig_top),
	.sin(sin),
	.sclk(sclk),
	.pclk_t(pclk_t),
	.pclk_m(pclk_m),
	.pclk_b(pclk_b)
);

//--- alpha_controller_top.sv
module alpha_controller_top #(
	parameter int step_cycles = 100 // cycles per sequencer step
) (
	input logic clock,
	input logic reset,
	input logic startup_button,
	input logic config_button,
	input alpha_config_pkg::config_word_t config_word, // latched at the config press
	output logic dreset,
	output logic sync,
	output logic tok_a_f2t,
	output logic trig_top,
	output logic sin,
	output logic sclk,
	output logic pclk_t,
	output logic pclk_m,
	output logic pclk_b
);

	logic startup_start; // strobes from the button path
	logic config_start;

	alpha_control_if ctl_if (); // raw levels, sequencers to pins

	button_edge_detector button_edge_detector_inst (
		.clock(clock),
		.reset(reset),
		.startup_button(startup_button),
		.config_button(config_button),
		.startup_start(startup_start),
		.config_start(config_start)
	);

	chip_startup_sequencer #(.step_cycles(step_cycles)) chip_startup_sequencer_inst (
		.clock(clock),
		.reset(reset),
		.startup_start(startup_start),
		.ctl(ctl_if.startup)
	);

	serial_config_shifter #(.step_cycles(step_cycles)) serial_config_shifter_inst (
		.clock(clock),
		.reset(reset),
		.config_start(config_start),
		.config_word(config_word),
		.ctl(ctl_if.cfg)
	);

	alpha_pin_driver alpha_pin_driver_inst (
		.clock(clock),
		.reset(reset),
		.ctl(ctl_if.pins),
		.dreset(dreset),
		.sync(sync),
		.tok_a_f2t(tok_a_f2t),
		.trig_top(trig_top),
		.sin(sin),
		.sclk(sclk),
		.pclk_t(pclk_t),
		.pclk_m(pclk_m),
		.pclk_b(pclk_b)
	);

endmodule

//--- alpha_monitor.sv
module alpha_monitor #(
	parameter int step_cycles = 100
) (
	input logic clock,
	input logic reset,
	input logic test_arm, // one cycle, starts watching a test
	input logic [3:0] test_kind, // 1 startup, 2 and 3 config
	input alpha_config_pkg::config_word_t test_word,
	input logic dreset,
	input logic sync,
	input logic tok_a_f2t,
	input logic trig_top,
	input logic sin,
	input logic sclk,
	input logic pclk_t,
	input logic pclk_m,
	input logic pclk_b,
	output logic test_done,
	output int tests_done,
	output int tests_failed,
	output int check_errors
);
	timeunit 1ns;
	timeprecision 1ps;
	import alpha_timing_pkg::*;
	import alpha_config_pkg::*;

	logic active;
	logic test_bad;
	logic [3:0] mode;
	config_word_t word; // expected word of the running test
	logic [3:0] lines, prev_lines, rises, falls; // {trig, token, sync, dreset}
	logic prev_sclk, in_high, held_sin;
	logic bits_q[$]; // sin taken at each sclk rise
	int cycle, last_rise, event_index, high_len, low_len;

	// startup pulses in the order the chip needs them
	function automatic logic [3:0] expected_line(input int index);
		case (index)
			0: return 4'b0001; // dreset
			1: return 4'b0010; // sync
			3: return 4'b1000; // trigger
			default: return 4'b0100; // both tokens
		endcase
	endfunction

	// rise to rise distance before pulse index
	function automatic int rise_spacing(input int index);
		if (index == 4) return (gap_steps + 1) * step_cycles; // across the long hold
		return 2 * step_cycles; // one step high, one step low
	endfunction

	function automatic logic expected_bit(input int slot);
		bit_index_t index;
		index = bit_index_t'(slot % $bits(config_word_t)); // dummy slots wrap
		return word[index];
	endfunction

	task automatic report_error(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		check_errors++;
		test_bad = 1'b1;
	endtask

	task automatic finish_test();
		if (mode != 4'd1) begin
			if (bits_q.size() != slot_count)
				report_error($sformatf("%0d sclk slots, expected %0d", bits_q.size(), slot_count));
			for (int i = 0; i < bits_q.size() && i < slot_count; i++) begin
				if (bits_q[i] != expected_bit(i))
					report_error($sformatf("sin slot %0d is %b, expected %b", i, bits_q[i],
						expected_bit(i)));
			end
		end
		tests_done++;
		if (test_bad) tests_failed++;
		$display("test %0d kind %0d word %h: %s", tests_done, mode, word,
			test_bad ? "fail" : "pass");
		active = 1'b0;
		test_done <= 1'b1;
	endtask

	always @(posedge clock) begin
		test_done <= 1'b0;
		lines = {trig_top, tok_a_f2t, sync, dreset};
		rises = lines & ~prev_lines;
		falls = prev_lines & ~lines;
		if (reset) begin
			active = 1'b0;
			cycle = 0;
			tests_done = 0;
			tests_failed = 0;
			check_errors = 0;
		end else if (test_arm) begin
			active = 1'b1;
			mode = test_kind;
			word = test_word;
			test_bad = 1'b0;
			event_index = 0;
			high_len = 0;
			low_len = 0;
			in_high = 1'b0; // a cut-off old sclk pulse is not judged
			bits_q.delete();
		end else if (active) begin
			if ($countones(lines) > 1) report_error("startup pulses overlap");
			if (dreset && !(pclk_t && pclk_m && pclk_b && sclk))
				report_error("clock line low while dreset high");
			if (mode == 4'd1) begin
				if (rises != 4'b0000) begin
					if (event_index >= 5) begin
						report_error("extra startup pulse");
					end else begin
						if (rises != expected_line(event_index))
							report_error($sformatf("pulse %0d on lines %b, expected %b",
								event_index, rises, expected_line(event_index)));
						if (event_index > 0 && cycle - last_rise != rise_spacing(event_index))
							report_error($sformatf("pulse %0d rose %0d cycles after the last, expected %0d",
								event_index, cycle - last_rise, rise_spacing(event_index)));
						last_rise = cycle;
						high_len = 0;
						event_index++;
					end
				end
				if (lines != 4'b0000) high_len++;
				if (falls != 4'b0000) begin
					if (high_len != step_cycles)
						report_error($sformatf("pulse %0d high %0d cycles", event_index - 1, high_len));
					if (event_index == 5) finish_test(); // second token done
				end
			end else begin
				if (lines != 4'b0000) report_error("startup line high during config shift");
				if (sclk && !prev_sclk) begin
					bits_q.push_back(sin);
					held_sin = sin;
					in_high = 1'b1;
					high_len = 0;
				end
				if (sclk) begin
					high_len++;
					low_len = 0;
					if (in_high && sin != held_sin) report_error("sin moved while sclk high");
				end else begin
					low_len++;
					if (prev_sclk && in_high && high_len != step_cycles)
						report_error($sformatf("sclk high %0d cycles", high_len));
					in_high = 1'b0;
					// quiet longer than any gap inside a shift
					if (bits_q.size() >= slot_count && low_len >= 3 * step_cycles) finish_test();
				end
			end
		end
		if (!reset) cycle++;
		prev_lines = lines;
		prev_sclk = sclk;
	end

endmodule

//--- alpha_pin_driver.sv
module alpha_pin_driver (
	input logic clock,
	input logic reset,
	alpha_control_if.pins ctl,
	output logic dreset,
	output logic sync,
	output logic tok_a_f2t,
	output logic trig_top,
	output logic sin,
	output logic sclk,
	output logic pclk_t, // top chip
	output logic pclk_m, // middle chip
	output logic pclk_b // bottom chip
);

	// one register stage on every pin
	always_ff @(posedge clock) begin
		if (reset) begin
			dreset <= 1'b0;
			sync <= 1'b0;
			tok_a_f2t <= 1'b0;
			trig_top <= 1'b0;
			sin <= 1'b0;
			sclk <= 1'b0;
			pclk_t <= 1'b0;
			pclk_m <= 1'b0;
			pclk_b <= 1'b0;
		end else begin
			dreset <= ctl.dreset;
			sync <= ctl.sync;
			tok_a_f2t <= ctl.tok_a_f2t;
			trig_top <= ctl.trig_top;
			sin <= ctl.sin;
			sclk <= ctl.sclk | ctl.dreset; // chip wants its clocks high during reset
			// pclk only ever rises with dreset
			pclk_t <= ctl.dreset;
			pclk_m <= ctl.dreset;
			pclk_b <= ctl.dreset;
		end
	end

endmodule

//--- alpha_timing_pkg.sv
package alpha_timing_pkg;

	// button synchronizer length, oldest two stages give the edge
	localparam int pickoff_depth = 7;

	// quiet hold between trigger and second token, in steps
	localparam int gap_steps = 1121;

	// cycle counter within one step or the long hold
	typedef logic [31:0] step_count_t;

	// startup sequencer, one line per group of states
	typedef enum logic [3:0] {
		idle, lead, dreset_on, dreset_off, sync_on, sync_off,
		token_on, token_off, trigger_on,
		hold, token2_on, token2_off
	} startup_state_t;

	// shifter states, prefixed so they do not clash with the startup names
	typedef enum logic [2:0] {
		shift_idle,
		shift_lead,
		shift_setup, // sin takes the next bit
		shift_clock_high,
		shift_clock_low // index moves on here
	} shift_state_t;

endpackage

//--- alpha_vectors.txt
// one test per line: first hex digit is the kind (1 startup, 2 config, 3 config re-pressed)
// the last four hex digits are the configuration word; a kind of 0 ends the list
10000
2a5c3
20001
2ffff
38e71
00000

//--- build.f
alpha_timing_pkg.sv
alpha_config_pkg.sv
alpha_control_if.sv
button_edge_detector.sv
chip_startup_sequencer.sv
serial_config_shifter.sv
alpha_pin_driver.sv
alpha_controller_top.sv
alpha_controller_asserts.sv
alpha_monitor.sv
tb_alpha_controller.sv

//--- button_edge_detector.sv
module button_edge_detector (
	input logic clock,
	input logic reset,
	input logic startup_button, // async, from the board
	input logic config_button,
	output logic startup_start, // one cycle per rise
	output logic config_start
);
	import alpha_timing_pkg::*;

	logic [1:0][pickoff_depth-1:0] pipe; // index 0 startup, 1 config
	logic [1:0] rise;

	// oldest stage low, next one high
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			rise[i] = (pipe[i][pickoff_depth-1:pickoff_depth-2] == 2'b01);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pipe <= '0;
			startup_start <= 1'b0;
			config_start <= 1'b0;
		end else begin
			pipe[0] <= {pipe[0][pickoff_depth-2:0], startup_button}; // newest at bit 0
			pipe[1] <= {pipe[1][pickoff_depth-2:0], config_button};
			startup_start <= rise[0];
			config_start <= rise[1];
		end
	end

endmodule

//--- chip_startup_sequencer.sv
module chip_startup_sequencer #(
	parameter int step_cycles = 100 // clock cycles per step
) (
	input logic clock,
	input logic reset,
	input logic startup_start, // one-cycle strobe
	alpha_control_if.startup ctl
);
	import alpha_timing_pkg::*;

	startup_state_t state, state_d;
	startup_state_t state_after; // where the current state goes when its time is up
	step_count_t count, count_d;
	step_count_t step_limit; // length of the current state in cycles

	always_comb begin
		if (state == hold) begin
			step_limit = step_count_t'(gap_steps * step_cycles); // long quiet wait
		end else begin
			step_limit = step_count_t'(step_cycles);
		end
		case (state)
			lead: state_after = dreset_on;
			dreset_on: state_after = dreset_off;
			dreset_off: state_after = sync_on;
			sync_on: state_after = sync_off;
			sync_off: state_after = token_on;
			token_on: state_after = token_off;
			token_off: state_after = trigger_on;
			trigger_on: state_after = hold; // no separate trigger-off step
			hold: state_after = token2_on;
			token2_on: state_after = token2_off;
			default: state_after = idle; // token2_off and idle
		endcase
	end

	// trigger rise to second token rise spans (gap_steps + 1) steps
	always_comb begin
		state_d = state;
		count_d = count + 1'b1;
		if (startup_start) begin // restart from anywhere
			state_d = lead;
			count_d = '0;
		end else if (state == idle) begin
			count_d = '0; // parked
		end else if (count == step_limit - 1'b1) begin
			state_d = state_after;
			count_d = '0;
		end
	end

	// lines follow the state being entered, so they line up with it
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			count <= '0;
			ctl.dreset <= 1'b0;
			ctl.sync <= 1'b0;
			ctl.tok_a_f2t <= 1'b0;
			ctl.trig_top <= 1'b0;
		end else begin
			state <= state_d;
			count <= count_d;
			ctl.dreset <= (state_d == dreset_on);
			ctl.sync <= (state_d == sync_on);
			ctl.tok_a_f2t <= (state_d == token_on) || (state_d == token2_on); // both tokens
			ctl.trig_top <= (state_d == trigger_on);
		end
	end

endmodule

//--- serial_config_shifter.sv
module serial_config_shifter #(
	parameter int step_cycles = 100 // clock cycles per step
) (
	input logic clock,
	input logic reset,
	input logic config_start, // one-cycle strobe
	input alpha_config_pkg::config_word_t config_word,
	alpha_control_if.cfg ctl
);
	import alpha_timing_pkg::*;
	import alpha_config_pkg::*;

	shift_state_t state, state_d, state_after;
	step_count_t count, count_d;
	config_word_t word_q; // held for the whole shift
	bit_index_t bit_index; // wraps, dummy slots resend bits 0..3
	slot_index_t slot; // slots already clocked
	logic step_done;

	always_comb begin
		step_done = (count == step_count_t'(step_cycles - 1));
		case (state)
			shift_lead: state_after = shift_setup;
			shift_setup: state_after = shift_clock_high;
			shift_clock_high: state_after = shift_clock_low;
			shift_clock_low: begin
				if (slot == slot_index_t'(slot_count)) begin
					state_after = shift_idle; // all slots sent
				end else begin
					state_after = shift_setup;
				end
			end
			default: state_after = shift_idle;
		endcase
	end

	always_comb begin
		state_d = state;
		count_d = count + 1'b1;
		if (config_start) begin // restart at bit 0
			state_d = shift_lead;
			count_d = '0;
		end else if (state == shift_idle) begin
			count_d = '0;
		end else if (step_done) begin
			state_d = state_after;
			count_d = '0;
		end
	end

	always_ff @(posedge clock) begin
		if (config_start) word_q <= config_word; // re-latched on every press
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= shift_idle;
			count <= '0;
			bit_index <= '0;
			slot <= '0;
			ctl.sin <= 1'b0;
			ctl.sclk <= 1'b0;
		end else begin
			state <= state_d;
			count <= count_d;
			ctl.sclk <= (state_d == shift_clock_high);
			if (config_start) begin
				bit_index <= '0;
				slot <= '0;
				ctl.sin <= 1'b0;
			end else if (state == shift_clock_high && state_d == shift_clock_low) begin
				bit_index <= bit_index + 1'b1; // falling sclk moves on
				slot <= slot + 1'b1;
			end else if (state != shift_setup && state_d == shift_setup) begin
				ctl.sin <= word_q[bit_index]; // stays put through the high phase
			end
		end
	end

endmodule

//--- tb_alpha_controller.sv
module tb_alpha_controller;
	timeunit 1ns;
	timeprecision 1ps;
	import alpha_config_pkg::*;

	localparam int step_cycles = 4;
	localparam int max_tests = 16;

	logic clock, reset, startup_button, config_button;
	config_word_t config_word;
	logic dreset, sync, tok_a_f2t, trig_top, sin, sclk, pclk_t, pclk_m, pclk_b;
	logic test_arm, test_done;
	logic [3:0] test_kind;
	config_word_t test_word;
	int tests_done, tests_failed, check_errors;
	logic [19:0] vectors [0:max_tests-1]; // kind in the top digit, word below
	int num_tests = 0;
	int bad_vectors = 0;
	int cycle_count = 0;
	int cycle_limit = 0; // 0 until the vectors are counted
	int assert_failures;

	alpha_controller_top #(.step_cycles(step_cycles)) alpha_controller_top_inst (
		.clock(clock), .reset(reset),
		.startup_button(startup_button), .config_button(config_button),
		.config_word(config_word),
		.dreset(dreset), .sync(sync), .tok_a_f2t(tok_a_f2t), .trig_top(trig_top),
		.sin(sin), .sclk(sclk), .pclk_t(pclk_t), .pclk_m(pclk_m), .pclk_b(pclk_b)
	);

	alpha_monitor #(.step_cycles(step_cycles)) alpha_monitor_inst (
		.clock(clock), .reset(reset),
		.test_arm(test_arm), .test_kind(test_kind), .test_word(test_word),
		.dreset(dreset), .sync(sync), .tok_a_f2t(tok_a_f2t), .trig_top(trig_top),
		.sin(sin), .sclk(sclk), .pclk_t(pclk_t), .pclk_m(pclk_m), .pclk_b(pclk_b),
		.test_done(test_done), .tests_done(tests_done),
		.tests_failed(tests_failed), .check_errors(check_errors)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock; // 40 ns period
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout: no result after %0d cycles", cycle_count);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// button high for 10 cycles, monitor armed on the first
	task automatic press_button(input logic use_config, input config_word_t word,
			input logic watch, input logic [3:0] kind);
		@(posedge clock);
		if (use_config) config_button <= 1'b1;
		else startup_button <= 1'b1;
		config_word <= word;
		if (watch) begin
			test_arm <= 1'b1;
			test_kind <= kind;
			test_word <= word;
		end
		@(posedge clock);
		test_arm <= 1'b0;
		repeat (9) @(posedge clock);
		startup_button <= 1'b0;
		config_button <= 1'b0;
	endtask

	task automatic wait_for_done();
		do @(posedge clock); while (test_done !== 1'b1);
	endtask

	task automatic run_test(input logic [19:0] vector);
		logic [3:0] kind;
		config_word_t word;
		kind = vector[19:16];
		word = vector[15:0];
		case (kind)
			4'd1: begin
				press_button(1'b0, word, 1'b1, kind);
				wait_for_done();
			end
			4'd2: begin
				press_button(1'b1, word, 1'b1, kind);
				wait_for_done();
			end
			4'd3: begin
				press_button(1'b1, ~word, 1'b0, kind); // this shift gets cut off
				repeat (6) @(posedge sclk);
				press_button(1'b1, word, 1'b1, kind); // lands in a low phase of sclk
				wait_for_done();
			end
			default: begin
				$display("vector file holds unknown test kind %0d", kind);
				bad_vectors++;
			end
		endcase
		repeat (20) @(posedge clock); // idle gap between tests
	endtask

	initial begin
		reset = 1'b1;
		startup_button = 1'b0;
		config_button = 1'b0;
		config_word = '0;
		test_arm = 1'b0;
		test_kind = '0;
		test_word = '0;
		for (int i = 0; i < max_tests; i++) vectors[i] = '0;
		$readmemh("alpha_vectors.txt", vectors);
		while (num_tests < max_tests && vectors[num_tests][19:16] != 4'd0) num_tests++;
		cycle_limit = num_tests * (1140 * step_cycles + 50);
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		repeat (5) @(posedge clock);
		for (int i = 0; i < num_tests; i++) run_test(vectors[i]);
		assert_failures = alpha_controller_top_inst.alpha_pin_driver_inst.alpha_controller_asserts_inst.failures;
		$display("done: %0d of %0d tests run, %0d failed, %0d check errors, %0d assertion failures",
			tests_done, num_tests, tests_failed, check_errors, assert_failures);
		if (num_tests > 0 && tests_done == num_tests && tests_failed == 0 && check_errors == 0
				&& assert_failures == 0 && bad_vectors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
